/* project.f */
src/invadersPkg.sv
src/fleetBus.sv
src/fleetMarcher.sv
src/invaderSlot.sv
src/fleetJudge.sv
src/shipGunner.sv
src/invadersTop.sv
verification/tickGen.sv
verification/invadersTb.sv

/* run.sh */
#!/bin/sh
# build and run the invaders testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module invadersTb \
	-f project.f -Mdir obj_dir -o invadersSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/invadersSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1

/* verification/invadersTb.sv */
`timescale 1ns/1ps

module invadersTb import invadersPkg::*; ();

	typedef enum int {checkReset, moveShip, fireMiss, fireHit, autoplay, freeze} testKind;

	typedef struct packed
	{
		testKind kind;
		logic restart;    // new game before the test
		logic [2:0] keys; // {moveLeft, moveRight, fire}
		int ticks;        // exact length or upper bound
		int expShipX;
		int expKills;
	} testRow;

	localparam int numTests = 10;
	localparam int watchMargin = 200; // restarts plus slack

	logic update;
	logic arstN;
	logic resetReq = 1'b0;
	logic moveLeft = 1'b0;
	logic moveRight = 1'b0;
	logic fire = 1'b0;
	coordX shipX;
	coordX bulletX;
	coordY bulletY;
	logic bulletLive;
	alienMask aliveMask;
	killCount kills;
	gameState state;

	testRow tests [numTests];
	string names [numTests];
	string testName;
	int tableSize = 0;
	int limitTicks = 0;
	logic tableReady = 1'b0;
	int checks = 0;
	int errors = 0;
	int testErrors = 0;
	int failedTests = 0;
	int shipModel = 200;
	logic [31:0] lfsr = 32'h69e2cbda;

	tickGen clock_i (.resetReq(resetReq), .update(update), .arstN(arstN));

	invadersTop dut_i
	(
		.update(update),
		.arstN(arstN),
		.moveLeft(moveLeft),
		.moveRight(moveRight),
		.fire(fire),
		.shipX(shipX),
		.bulletX(bulletX),
		.bulletY(bulletY),
		.bulletLive(bulletLive),
		.aliveMask(aliveMask),
		.kills(kills),
		.state(state)
	);

	task automatic addTest(input string name, input testKind kind, input logic restart,
		input logic [2:0] keys, input int ticks, input int expShipX, input int expKills);
		tests[tableSize] = '{kind, restart, keys, ticks, expShipX, expKills};
		names[tableSize] = name;
		tableSize++;
	endtask

	// Galois LFSR, stepped once per bit taken
	function automatic logic randomBit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return b;
	endfunction

	function automatic int countDead(input alienMask mask);
		int n;
		n = 0;
		for (int i = 0; i < alienCount; i++)
			if (!mask[i])
				n++;
		return n;
	endfunction

	function automatic int nextShipX(input int x, input logic [2:0] keys);
		if (keys[2] && !keys[1])
			return (x + 1014) % 1024; // 10 bit position wraps
		else if (keys[1] && !keys[2])
			return (x + 10) % 1024;
		return x;
	endfunction

	task automatic tick(input logic [2:0] keys);
		{moveLeft, moveRight, fire} = keys;
		@(posedge update);
		#1;
	endtask

	task automatic restartGame();
		resetReq = 1'b1;
		wait (!arstN);
		resetReq = 1'b0;
		wait (arstN);
	endtask

	task automatic checkValue(input string what, input int actual, input int expected);
		checks++;
		assert (actual == expected)
		else
		begin
			testErrors++;
			$display("Fail %s: %s expected %0d, actual %0d", testName, what, expected, actual);
		end
	endtask

	task automatic checkTrue(input logic ok, input string problem);
		checks++;
		assert (ok)
		else
		begin
			testErrors++;
			$display("Error in %s: %s", testName, problem);
		end
	endtask

	task automatic runTest(input int t);
		testRow row;
		int n;
		int liveModel;
		int bxModel;
		int byModel;
		logic [2:0] keys;
		int hold [6];
		row = tests[t];
		testName = names[t];
		testErrors = 0;
		{moveLeft, moveRight, fire} = 3'b000;
		if (row.restart)
		begin
			restartGame();
			shipModel = 200;
		end
		case (row.kind)
			checkReset:
			begin
				checkValue("bulletLive", int'(bulletLive), 0);
				checkValue("aliveMask", int'(aliveMask), 32'h7fff);
				checkValue("state", int'(state), int'(playing));
			end
			moveShip:
				for (n = 0; n < row.ticks; n++)
				begin
					tick(row.keys);
					shipModel = nextShipX(shipModel, row.keys);
					checkValue("shipX", int'(shipX), shipModel);
				end
			fireMiss:
				for (n = 0; n < row.ticks; n++)
				begin
					tick(n == 0 ? row.keys : 3'b000);
					if (n == 0)
					begin
						liveModel = 1; // launched from the muzzle
						bxModel = shipModel + 15;
						byModel = 450;
					end
					else if (liveModel == 1 && byModel <= 20)
					begin
						liveModel = 0; // parked off screen
						bxModel = 650;
						byModel = 50;
					end
					else if (liveModel == 1)
						byModel -= 10;
					checkValue("bulletLive", int'(bulletLive), liveModel);
					checkValue("bulletX", int'(bulletX), bxModel);
					checkValue("bulletY", int'(bulletY), byModel);
				end
			fireHit:
			begin
				tick(row.keys);
				checkValue("bulletLive", int'(bulletLive), 1);
				n = 1;
				while (bulletLive && n < row.ticks)
				begin
					tick(3'b000);
					n++;
				end
				checkTrue(!bulletLive, "bullet still in flight at the tick bound");
				checkValue("dead invaders", countDead(aliveMask), 1);
			end
			autoplay:
			begin
				n = 0;
				while (state == playing && n < row.ticks)
				begin
					keys[2] = randomBit();
					keys[1] = randomBit();
					keys[0] = 1'b1; // keep firing
					tick(keys);
					shipModel = nextShipX(shipModel, keys);
					checkValue("shipX", int'(shipX), shipModel);
					checkValue("kills", int'(kills), countDead(aliveMask));
					checkValue("won flag", int'(state == won), int'(kills == 4'd15));
					n++;
				end
				checkTrue(state != playing, "game still running at the tick bound");
			end
			freeze:
			begin
				checkTrue(state != playing, "game had not ended before the freeze test");
				hold = '{int'(shipX), int'(bulletX), int'(bulletY), int'(bulletLive),
					int'(aliveMask), int'(state)};
				for (n = 0; n < row.ticks; n++)
				begin
					tick(row.keys);
					checkValue("shipX", int'(shipX), hold[0]);
					checkValue("bulletX", int'(bulletX), hold[1]);
					checkValue("bulletY", int'(bulletY), hold[2]);
					checkValue("bulletLive", int'(bulletLive), hold[3]);
					checkValue("aliveMask", int'(aliveMask), hold[4]);
					checkValue("state", int'(state), hold[5]);
				end
			end
		endcase
		if (row.kind != autoplay && row.kind != freeze)
		begin
			checkValue("shipX", int'(shipX), row.expShipX);
			checkValue("kills", int'(kills), row.expKills);
		end
		errors += testErrors;
		if (testErrors == 0)
			$display("test %0d %s: ok", t, testName);
		else
		begin
			failedTests++;
			$display("test %0d %s: %0d errors", t, testName, testErrors);
		end
	endtask

	initial
	begin
		addTest("reset values", checkReset, 1'b0, 3'b000, 0, 200, 0);
		addTest("move left", moveShip, 1'b0, 3'b100, 3, 170, 0);
		addTest("move right", moveShip, 1'b0, 3'b010, 5, 220, 0);
		addTest("both held", moveShip, 1'b0, 3'b110, 4, 220, 0);
		addTest("ship to 600", moveShip, 1'b0, 3'b010, 38, 600, 0);
		addTest("bullet miss", fireMiss, 1'b0, 3'b001, 45, 600, 0);
		addTest("bullet hit", fireHit, 1'b1, 3'b001, 60, 200, 1);
		addTest("autoplay", autoplay, 1'b1, 3'b001, 5000, 0, 0);
		addTest("freeze left fire", freeze, 1'b0, 3'b101, 20, 0, 0);
		addTest("freeze right", freeze, 1'b0, 3'b010, 20, 0, 0);
		limitTicks = watchMargin;
		for (int t = 0; t < tableSize; t++)
			limitTicks += tests[t].ticks;
		tableReady = 1'b1;
		wait (arstN);
		for (int t = 0; t < tableSize; t++)
			runTest(t);
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tableSize, failedTests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		wait (tableReady);
		repeat (limitTicks) @(posedge update);
		$display("watchdog: run did not finish within %0d ticks", limitTicks);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* verification/tickGen.sv */
`timescale 1ns/1ps

module tickGen
(
	input logic resetReq,
	output logic update,
	output logic arstN
);

	initial
	begin
		update = 1'b0;
		forever #5 update = ~update; // 10 ns period
	end

	// two cycles of reset at start, again on each restart request
	always
	begin
		arstN = 1'b0;
		repeat (2) @(posedge update);
		#2 arstN = 1'b1;
		@(posedge resetReq);
	end

endmodule

/* src/invadersTop.sv */
`timescale 1ns/1ps

module invadersTop import invadersPkg::*;
(
	input logic update,
	input logic arstN,
	input logic moveLeft,
	input logic moveRight,
	input logic fire,
	output coordX shipX,
	output coordX bulletX,
	output coordY bulletY,
	output logic bulletLive,
	output alienMask aliveMask,
	output killCount kills,
	output gameState state
);

	alienMask hitReqs;
	alienMask lefts;
	alienMask rights;
	alienMask bottoms;
	alienMask killGrant;
	logic hitTaken;
	logic anyLeft;
	logic anyRight;

	fleetBus bus ();

	fleetMarcher marcher_i
	(
		.update(update),
		.arstN(arstN),
		.bus(bus.marcher),
		.anyLeft(anyLeft),
		.anyRight(anyRight),
		.state(state)
	);

	for (genvar i = 0; i < alienCount; i++)
	begin : slots
		invaderSlot #(.slotIndex(i)) slot_i
		(
			.update(update),
			.arstN(arstN),
			.bus(bus.slot),
			.killGrant(killGrant[i]),
			.alive(aliveMask[i]),
			.atLeft(lefts[i]),
			.atRight(rights[i]),
			.atBottom(bottoms[i]),
			.hitReq(hitReqs[i])
		);
	end

	fleetJudge judge_i
	(
		.update(update),
		.arstN(arstN),
		.hitReqs(hitReqs),
		.lefts(lefts),
		.rights(rights),
		.bottoms(bottoms),
		.killGrant(killGrant),
		.hitTaken(hitTaken),
		.anyLeft(anyLeft),
		.anyRight(anyRight),
		.kills(kills),
		.state(state)
	);

	shipGunner gunner_i
	(
		.update(update),
		.arstN(arstN),
		.moveLeft(moveLeft),
		.moveRight(moveRight),
		.fire(fire),
		.hitTaken(hitTaken),
		.state(state),
		.bus(bus.gunner),
		.shipX(shipX)
	);

	assign bulletX = bus.bulletX;
	assign bulletY = bus.bulletY;
	assign bulletLive = bus.bulletLive;

endmodule

/* src/shipGunner.sv */
`timescale 1ns/1ps

module shipGunner import invadersPkg::*;
(
	input logic update,
	input logic arstN,
	input logic moveLeft,
	input logic moveRight,
	input logic fire,
	input logic hitTaken,
	input gameState state,
	fleetBus.gunner bus,
	output coordX shipX
);

	always_ff @(posedge update or negedge arstN)
	begin
		if (!arstN)
		begin
			shipX <= shipStartX;
			bus.bulletX <= parkX;
			bus.bulletY <= parkY;
			bus.bulletLive <= 1'b0;
		end
		else if (state == playing)
		begin
			if (moveLeft && !moveRight)
				shipX <= shipX - shipStep;
			else if (moveRight && !moveLeft)
				shipX <= shipX + shipStep; // both pressed cancel out

			if (!bus.bulletLive)
			begin
				if (fire)
				begin
					bus.bulletLive <= 1'b1;
					bus.bulletX <= shipX + muzzleOffset;
					bus.bulletY <= shipY;
				end
			end
			else if (hitTaken || (bus.bulletY <= bulletTop))
			begin
				bus.bulletLive <= 1'b0; // ready to fire again
				bus.bulletX <= parkX;
				bus.bulletY <= parkY;
			end
			else
				bus.bulletY <= bus.bulletY - bulletStep;
		end
	end

endmodule

/* src/fleetJudge.sv */
`timescale 1ns/1ps

module fleetJudge import invadersPkg::*;
(
	input logic update,
	input logic arstN,
	input alienMask hitReqs,
	input alienMask lefts,
	input alienMask rights,
	input alienMask bottoms,
	output alienMask killGrant,
	output logic hitTaken,
	output logic anyLeft,
	output logic anyRight,
	output killCount kills,
	output gameState state
);

	logic lastKill;

	// lowest requesting slot wins and nothing is granted after the game ends
	assign killGrant = (state == playing) ? (hitReqs & (~hitReqs + 15'd1)) : '0;
	assign hitTaken = |killGrant;
	assign anyLeft = |lefts;
	assign anyRight = |rights;
	assign lastKill = hitTaken && (kills == killCount'(alienCount - 1));

	always_ff @(posedge update or negedge arstN)
	begin
		if (!arstN)
		begin
			kills <= '0;
			state <= playing;
		end
		else
		begin
			if (hitTaken)
				kills <= kills + 4'd1;
			if (state == playing)
			begin
				// won shows up on the same edge as the final count
				if (lastKill)
					state <= won;
				else if (|bottoms)
					state <= lost; // invaders reached the ground
			end
		end
	end

	countNoWrap: assert property (@(posedge update) disable iff (!arstN)
		hitTaken |-> (kills != killCount'(alienCount)))
		else $error("kill counted after the last invader was gone");

endmodule

/* src/invaderSlot.sv */
`timescale 1ns/1ps

module invaderSlot import invadersPkg::*;
#(
	parameter int slotIndex = 0
)
(
	input logic update,
	input logic arstN,
	fleetBus.slot bus,
	input logic killGrant,
	output logic alive,
	output logic atLeft,
	output logic atRight,
	output logic atBottom,
	output logic hitReq
);

	localparam int rowIndex = slotIndex / rowLength;
	localparam coordX sizeX = coordX'(rowSize[rowIndex]);
	localparam coordY sizeY = coordY'(rowSize[rowIndex]);

	coordX posX;
	coordY posY;
	logic insideX;
	logic insideY;

	always_ff @(posedge update or negedge arstN)
	begin
		if (!arstN)
		begin
			posX <= startX[slotIndex];
			posY <= startY[rowIndex];
			alive <= 1'b1;
		end
		else
		begin
			if (bus.stepEn)
			begin
				if (bus.dirRight)
					posX <= posX + marchStepX;
				else
					posX <= posX - marchStepX;
				if (bus.dropDown)
					posY <= posY + dropStepY;
			end
			if (killGrant)
				alive <= 1'b0;
		end
	end

	// dead invaders keep marching but no longer steer the fleet
	assign atLeft = alive && (posX <= leftLimit);
	assign atRight = alive && (posX >= rightLimit);
	assign atBottom = alive && (posY >= rowBottom[rowIndex]);

	assign insideX = (bus.bulletX >= posX) && (bus.bulletX <= posX + sizeX);
	assign insideY = (bus.bulletY >= posY) && (bus.bulletY <= posY + sizeY);
	assign hitReq = alive && bus.bulletLive && insideX && insideY;

	grantOnlyOnHit: assert property (@(posedge update) disable iff (!arstN)
		killGrant |-> hitReq)
		else $error("slot %0d granted a kill it did not request", slotIndex);

endmodule

/* src/fleetMarcher.sv */
`timescale 1ns/1ps

module fleetMarcher import invadersPkg::*;
(
	input logic update,
	input logic arstN,
	fleetBus.marcher bus,
	input logic anyLeft,
	input logic anyRight,
	input gameState state
);

	marchSpeed stepCnt;
	marchSpeed speed;
	logic movingRight;
	logic atEdge;

	assign atEdge = anyLeft || anyRight;
	assign bus.stepEn = (state == playing) && (stepCnt == speed);
	assign bus.dropDown = bus.stepEn && atEdge;
	// a drop bounces the fleet back inward off whichever edge it hit
	assign bus.dirRight = bus.dropDown ? anyLeft : movingRight;

	always_ff @(posedge update or negedge arstN)
	begin
		if (!arstN)
		begin
			stepCnt <= '0;
			speed <= startSpeed;
			movingRight <= 1'b1;
		end
		else if (state == playing) // fleet freezes once the game is over
		begin
			if (bus.stepEn)
				stepCnt <= '0;
			else
				stepCnt <= stepCnt + 4'd1;
			if (bus.dropDown)
			begin
				movingRight <= bus.dirRight;
				if (speed > minSpeed)
					speed <= speed - 4'd1; // faster after every reversal
			end
		end
	end

	reverseOnDrop: assert property (@(posedge update) disable iff (!arstN)
		bus.dropDown |-> (bus.dirRight != movingRight))
		else $error("fleet dropped without reversing its march");

endmodule

/* src/fleetBus.sv */
`timescale 1ns/1ps

interface fleetBus import invadersPkg::*; ();

	logic stepEn;   // fleet moves this tick
	logic dirRight; // direction of this step
	logic dropDown; // step also drops one row
	coordX bulletX;
	coordY bulletY;
	logic bulletLive;

	modport marcher
	(
		output stepEn, dirRight, dropDown
	);

	modport gunner
	(
		output bulletX, bulletY, bulletLive
	);

	modport slot
	(
		input stepEn, dirRight, dropDown,
		input bulletX, bulletY, bulletLive
	);

endinterface

/* src/invadersPkg.sv */
package invadersPkg;

	typedef logic [9:0] coordX;     // horizontal playfield position
	typedef logic [8:0] coordY;     // vertical playfield position
	typedef logic [14:0] alienMask; // one bit per invader, row-major
	typedef logic [3:0] killCount;
	typedef logic [3:0] marchSpeed; // ticks between fleet steps, minus one

	typedef enum logic [1:0]
	{
		playing,
		won,
		lost
	} gameState;

	localparam int alienCount = 15;
	localparam int rowLength = 5; // invaders per row

	// rows A, B and C from the front of the fleet to the back
	localparam int rowSize [3] = '{35, 25, 15}; // square hit box
	localparam coordY rowBottom [3] = '{9'd400, 9'd400, 9'd430};
	localparam coordY startY [3] = '{9'd120, 9'd80, 9'd50};

	localparam coordX startX [alienCount] = '{
		10'd100, 10'd155, 10'd210, 10'd265, 10'd320,
		10'd105, 10'd160, 10'd215, 10'd270, 10'd325,
		10'd110, 10'd165, 10'd220, 10'd275, 10'd330
	};

	localparam coordX marchStepX = 10'd20;
	localparam coordY dropStepY = 9'd35;
	localparam coordX leftLimit = 10'd20;
	localparam coordX rightLimit = 10'd550;

	localparam marchSpeed startSpeed = 4'd11;
	localparam marchSpeed minSpeed = 4'd1; // fastest march, one step every two ticks

	localparam coordX shipStartX = 10'd200;
	localparam coordY shipY = 9'd450;
	localparam coordX shipStep = 10'd10;
	localparam coordX muzzleOffset = 10'd15; // gun sits mid-ship

	localparam coordY bulletStep = 9'd10;
	localparam coordY bulletTop = 9'd20;
	localparam coordX parkX = 10'd650; // off screen to the right
	localparam coordY parkY = 9'd50;

endpackage
